//--- common/uartPkg.sv
// data types shared by both serial engines and the testbench.
package uartPkg;

	// character width of an 8N1 frame.
	localparam int byteBits = 8;

	// bits needed to index a data bit.
	localparam int indexBits = $clog2(byteBits);

	// one character as carried on the line.
	typedef logic [byteBits-1:0] uartByte_t;

	// position of the current data bit, LSB first.
	typedef logic [indexBits-1:0] bitIndex_t;

	// index of the final data bit before the stop bit.
	localparam bitIndex_t lastDataBit = bitIndex_t'(byteBits - 1);

endpackage

//--- common/uartStatePkg.sv
// FSM encodings of the transmit and receive engines.
package uartStatePkg;

	// transmitter walks the frame one section at a time.
	typedef enum logic [1:0] {
		txIdle,
		txStartBit,
		txDataBits,
		txStopBit
	} txState_t;

	// receiver adds a wait for a high line after a bad stop bit.
	typedef enum logic [2:0] {
		rxIdle,
		rxStartBit,
		rxDataBits,
		rxStopBit,
		rxWaitIdle
	} rxState_t;

endpackage

//--- dv/uartCoreTb.sv
`timescale 1ns/1ps

// loopback testbench for the UART core.
// tx feeds rx unless a hand-made frame is being played in.
module uartCoreTb
	import uartPkg::*;
();

	localparam int clockScaleBits = 16;
	localparam int rowCount = 11;

	// one table row with stimulus first and expected outcome last.
	typedef struct packed {
		logic [clockScaleBits-1:0] cyclesPerBit;
		uartByte_t data;
		logic [7:0] blockCycles;
		logic corruptStop;
		logic strobeBusy;
		logic randomData;
		logic expectError;
	} stimRow_t;

	// period, byte, block cycles, corrupt stop, strobe while busy, random, framing error.
	localparam stimRow_t rows [rowCount] = '{
		'{16'd3, 8'h55, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0},
		'{16'd3, 8'ha3, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0},
		'{16'd7, 8'h0f, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0},
		'{16'd16, 8'hc6, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0},
		'{16'd7, 8'h3c, 8'd12, 1'b0, 1'b0, 1'b0, 1'b0},
		'{16'd7, 8'h81, 8'd0, 1'b0, 1'b1, 1'b0, 1'b0},
		'{16'd7, 8'h00, 8'd0, 1'b0, 1'b0, 1'b1, 1'b0},
		'{16'd7, 8'h00, 8'd0, 1'b0, 1'b0, 1'b1, 1'b0},
		'{16'd7, 8'h00, 8'd0, 1'b0, 1'b0, 1'b1, 1'b0},
		'{16'd7, 8'he7, 8'd0, 1'b1, 1'b0, 1'b0, 1'b1},
		'{16'd7, 8'h5a, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0}
	};

	logic clk;
	logic rst;
	logic [clockScaleBits-1:0] cyclesPerBit;
	uartByte_t txData;
	logic txValid;
	logic blockTransmission;
	logic rxLine;
	logic tx;
	logic txBusy;
	uartByte_t rxData;
	logic rxValid;
	logic rxFramingError;

	// hand-made frame source for the framing-error row.
	logic useLocalFrame;
	logic localLine;
	// bytes sent and not yet seen on rxData in order.
	uartByte_t expectQ [$];
	uartByte_t lastGoodByte;
	int goodSent = 0;
	int badSent = 0;
	int errorCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	// loopback mux.
	assign rxLine = useLocalFrame ? localLine : tx;

	uartCore #(
		.clockScaleBits(clockScaleBits)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.cyclesPerBit(cyclesPerBit),
		.txData(txData),
		.txValid(txValid),
		.blockTransmission(blockTransmission),
		.rx(rxLine),
		.tx(tx),
		.txBusy(txBusy),
		.rxData(rxData),
		.rxValid(rxValid),
		.rxFramingError(rxFramingError)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkBit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			reportFailure($sformatf("CHECK FAILED %s: got %h, expected %h",
				name, actual, expected));
		end
	endtask

	task automatic checkByte(input string name, input uartByte_t actual,
		input uartByte_t expected);
		if (actual !== expected) begin
			reportFailure($sformatf("CHECK FAILED %s: got %h, expected %h",
				name, actual, expected));
		end
	endtask

	task automatic checkCount(input string name, input int actual, input int expected);
		if (actual != expected) begin
			reportFailure($sformatf("CHECK FAILED %s: got %h, expected %h",
				name, actual, expected));
		end
	endtask

	// every drive and sample lands 1 ns after the rising edge.
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	// 8N1 line level for bit k of a frame where k = 0 is the start bit.
	function automatic logic frameBit(input uartByte_t value, input int k,
		input logic stopLevel);
		uartByte_t shifted;
		shifted = value >> (k - 1);
		if (k == 0) begin
			return 1'b0;
		end
		if (k == 9) begin
			return stopLevel;
		end
		return shifted[0];
	endfunction

	// send one byte, then sample tx in the middle of every bit.
	task automatic sendByte(input uartByte_t value, input int period, input logic strobeBusy);
		int half;
		int k;
		half = period / 2;
		while (txBusy) begin
			nextCycle();
		end
		txData = value;
		txValid = 1'b1;
		nextCycle();
		// optional second strobe lands while busy and must be dropped.
		if (strobeBusy) begin
			txData = ~value;
		end else begin
			txValid = 1'b0;
		end
		nextCycle();
		txValid = 1'b0;
		repeat (half - 1) nextCycle();
		for (k = 0; k < 10; k++) begin
			if (k > 0) begin
				repeat (period) nextCycle();
			end
			checkBit($sformatf("tx bit %0d", k), tx, frameBit(value, k, 1'b1));
			checkBit("txBusy", txBusy, 1'b1);
		end
		// busy drops right after the last stop-bit cycle.
		repeat (period - half - 1) nextCycle();
		checkBit("txBusy", txBusy, 1'b1);
		nextCycle();
		checkBit("txBusy", txBusy, 1'b0);
	endtask

	// a strobe during blocked idle must not start a frame.
	task automatic holdBlocked(input uartByte_t value, input int blockCycles);
		int c;
		blockTransmission = 1'b1;
		nextCycle();
		for (c = 0; c < blockCycles; c++) begin
			checkBit("txBusy", txBusy, 1'b1);
			checkBit("tx", tx, 1'b1);
			txData = ~value;
			txValid = (c == 2);
			nextCycle();
		end
		txValid = 1'b0;
		blockTransmission = 1'b0;
	endtask

	// plays a frame straight into rx with the transmitter's bit times.
	task automatic driveLocalFrame(input uartByte_t value, input int period);
		int k;
		useLocalFrame = 1'b1;
		for (k = 0; k < 10; k++) begin
			localLine = frameBit(value, k, 1'b0);
			repeat (period) nextCycle();
		end
		localLine = 1'b1;
		useLocalFrame = 1'b0;
	endtask

	// wait for the receiver to catch up, then compare totals.
	task automatic settleRow();
		while (expectQ.size() != 0 || errorCount < badSent) begin
			nextCycle();
		end
		repeat (2) nextCycle();
		checkCount("rxFramingError pulses", errorCount, badSent);
		checkByte("rxData", rxData, lastGoodByte);
		checkBit("txBusy", txBusy, 1'b0);
		checkBit("tx", tx, 1'b1);
	endtask

	// receive monitor samples at the falling edge where outputs are settled.
	always @(negedge clk) begin
		if (!rst && rxValid) begin
			if (expectQ.size() == 0) begin
				reportFailure("rxValid pulsed with no byte outstanding");
			end else begin
				checkByte("rxData", rxData, expectQ.pop_front());
			end
		end
		if (!rst && rxFramingError) begin
			errorCount = errorCount + 1;
		end
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			reportFailure($sformatf("timeout after %0d cycles, DUT never finished", cycleCount));
		end
	end

	initial begin
		int i;
		int period;
		uartByte_t value;
		logic lastOfGroup;
		void'($urandom(32'hadd1_aa60));
		cycleLimit = 200;
		for (i = 0; i < rowCount; i++) begin
			cycleLimit += 12 * (int'(rows[i].cyclesPerBit) + 1) + int'(rows[i].blockCycles);
		end
		rst = 1'b1;
		cyclesPerBit = rows[0].cyclesPerBit;
		txData = '0;
		txValid = 1'b0;
		blockTransmission = 1'b0;
		useLocalFrame = 1'b0;
		localLine = 1'b1;
		lastGoodByte = '0;
		repeat (10) nextCycle();
		rst = 1'b0;
		// quiet idle line after reset.
		repeat (8) begin
			nextCycle();
			checkBit("tx", tx, 1'b1);
			checkBit("txBusy", txBusy, 1'b0);
			checkBit("rxValid", rxValid, 1'b0);
			checkBit("rxFramingError", rxFramingError, 1'b0);
			checkByte("rxData", rxData, '0);
		end
		for (i = 0; i < rowCount; i++) begin
			cyclesPerBit = rows[i].cyclesPerBit;
			period = int'(rows[i].cyclesPerBit) + 1;
			value = rows[i].randomData ? uartByte_t'($urandom()) : rows[i].data;
			if (rows[i].expectError) begin
				badSent++;
			end else begin
				expectQ.push_back(value);
				goodSent++;
				lastGoodByte = value;
			end
			if (rows[i].corruptStop) begin
				driveLocalFrame(value, period);
			end else begin
				if (rows[i].blockCycles != 0) begin
					holdBlocked(value, int'(rows[i].blockCycles));
				end
				sendByte(value, period, rows[i].strobeBusy);
			end
			// random rows go out back to back and settle after the group.
			lastOfGroup = 1'b1;
			if (i + 1 < rowCount) begin
				lastOfGroup = !(rows[i].randomData && rows[i + 1].randomData);
			end
			if (lastOfGroup) begin
				settleRow();
			end
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- flist.f
common/uartPkg.sv
common/uartStatePkg.sv
uart/uartTx.sv
uart/uartRx.sv
source/uartCore.sv
dv/uartCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the UART core testbench with Verilator.
# The exit status is the simulator's, nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=uartCoreSim

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module uartCoreTb --Mdir "$buildDir" -o "$simName" -f flist.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

"./$buildDir/$simName"
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0

//--- source/uartCore.sv
`timescale 1ns/1ps

// UART core, one transmitter and one receiver.
// both engines run from the same bit period.
module uartCore
	import uartPkg::*;
#(
	// width of the bit-period count.
	parameter int clockScaleBits = 16
) (
	input logic clk,
	input logic rst,
	// clock cycles per bit, minus one, held during operation.
	input logic [clockScaleBits-1:0] cyclesPerBit,
	input uartByte_t txData,
	input logic txValid,
	input logic blockTransmission,
	input logic rx,
	output logic tx,
	output logic txBusy,
	output uartByte_t rxData,
	output logic rxValid,
	output logic rxFramingError
);

	// transmit side.
	uartTx #(
		.clockScaleBits(clockScaleBits)
	) tx0 (
		.clk(clk),
		.rst(rst),
		.cyclesPerBit(cyclesPerBit),
		.data(txData),
		.dataValid(txValid),
		.blockTransmission(blockTransmission),
		.tx(tx),
		.busy(txBusy)
	);

	// receive side, no back-pressure.
	uartRx #(
		.clockScaleBits(clockScaleBits)
	) rx0 (
		.clk(clk),
		.rst(rst),
		.cyclesPerBit(cyclesPerBit),
		.rx(rx),
		.data(rxData),
		.dataValid(rxValid),
		.framingError(rxFramingError)
	);

endmodule

//--- uart/uartRx.sv
`timescale 1ns/1ps

// 8N1 serial receiver.
// mid-bit sampling, glitch rejection on the start bit, stop-bit framing check.
module uartRx
	import uartPkg::*;
	import uartStatePkg::*;
#(
	parameter int clockScaleBits = 16
) (
	input logic clk,
	input logic rst,
	// clock cycles per bit, minus one.
	input logic [clockScaleBits-1:0] cyclesPerBit,
	// asynchronous serial input.
	input logic rx,
	output uartByte_t data,
	output logic dataValid,
	output logic framingError
);

	logic rxMeta;
	logic rxSync;
	rxState_t state;
	logic [clockScaleBits-1:0] bitTimer;
	logic [clockScaleBits-1:0] halfBit;
	bitIndex_t bitIndex;
	uartByte_t shiftReg;
	logic sampleTick;

	// delay to the middle of the start bit.
	assign halfBit = cyclesPerBit >> 1;
	// data bit sample point.
	assign sampleTick = (state == rxDataBits) && (bitTimer == '0);

	// two-flop synchronizer.
	// reset to the idle level so no false start edge follows reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end else begin
			rxMeta <= rx;
			rxSync <= rxMeta;
		end
	end

	// LSB arrives first, so shift in from the top.
	always_ff @(posedge clk) begin
		if (sampleTick) begin
			shiftReg <= {rxSync, shiftReg[byteBits-1:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rxIdle;
			bitTimer <= '0;
			bitIndex <= '0;
			data <= '0;
			dataValid <= 1'b0;
			framingError <= 1'b0;
		end else begin
			// pulses last a single cycle.
			dataValid <= 1'b0;
			framingError <= 1'b0;
			case (state)
				rxIdle: begin
					// line is known high here, so low means a falling edge.
					bitIndex <= '0;
					bitTimer <= halfBit;
					if (!rxSync) begin
						state <= rxStartBit;
					end
				end
				rxStartBit: begin
					if (bitTimer == '0) begin
						// still low at mid start, a real frame.
						if (!rxSync) begin
							bitTimer <= cyclesPerBit;
							state <= rxDataBits;
						end else begin
							// glitch, drop it quietly.
							state <= rxIdle;
						end
					end else begin
						bitTimer <= bitTimer - 1'b1;
					end
				end
				rxDataBits: begin
					if (bitTimer == '0) begin
						bitTimer <= cyclesPerBit;
						if (bitIndex == lastDataBit) begin
							state <= rxStopBit;
						end else begin
							bitIndex <= bitIndex + 1'b1;
						end
					end else begin
						bitTimer <= bitTimer - 1'b1;
					end
				end
				rxStopBit: begin
					if (bitTimer == '0) begin
						if (rxSync) begin
							// good frame, publish the byte.
							data <= shiftReg;
							dataValid <= 1'b1;
							state <= rxIdle;
						end else begin
							// data stays at the last good byte.
							framingError <= 1'b1;
							state <= rxWaitIdle;
						end
					end else begin
						bitTimer <= bitTimer - 1'b1;
					end
				end
				rxWaitIdle: begin
					// hunt again only once the line is back high.
					if (rxSync) begin
						state <= rxIdle;
					end
				end
				default: begin
					state <= rxIdle;
				end
			endcase
		end
	end

	// a frame ends either good or bad, never both.
	pulsesExclusive: assert property (@(posedge clk) disable iff (rst)
		!(dataValid && framingError))
		else $error("uartRx: valid and framing error together");

	validOneCycle: assert property (@(posedge clk) disable iff (rst)
		dataValid |=> !dataValid)
		else $error("uartRx: dataValid longer than one cycle");

	errorOneCycle: assert property (@(posedge clk) disable iff (rst)
		framingError |=> !framingError)
		else $error("uartRx: framingError longer than one cycle");

endmodule

//--- uart/uartTx.sv
`timescale 1ns/1ps

// 8N1 serial transmitter.
// one frame per accepted byte with flow control via blockTransmission.
module uartTx
	import uartPkg::*;
	import uartStatePkg::*;
#(
	parameter int clockScaleBits = 16
) (
	input logic clk,
	input logic rst,
	// clock cycles per bit, minus one.
	input logic [clockScaleBits-1:0] cyclesPerBit,
	input uartByte_t data,
	input logic dataValid,
	// level sensitive block that holds the engine in idle.
	input logic blockTransmission,
	output logic tx,
	output logic busy
);

	txState_t state;
	logic [clockScaleBits-1:0] bitTimer;
	bitIndex_t bitIndex;
	bitIndex_t nextIndex;
	uartByte_t txByte;
	logic accept;
	logic bitDone;

	// strobe only counts in idle with the block released.
	assign accept = (state == txIdle) && !blockTransmission && dataValid;
	// busy also covers a blocked idle engine.
	assign busy = (state != txIdle) || blockTransmission;
	// last cycle of the current bit.
	assign bitDone = (bitTimer == cyclesPerBit);
	assign nextIndex = bitIndex + 1'b1;

	// byte is latched on acceptance, so the source may move on.
	always_ff @(posedge clk) begin
		if (accept) begin
			txByte <= data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= txIdle;
			bitTimer <= '0;
			bitIndex <= '0;
			// idle line is high.
			tx <= 1'b1;
		end else begin
			case (state)
				txIdle: begin
					bitTimer <= '0;
					bitIndex <= '0;
					if (accept) begin
						// start bit on the next cycle.
						tx <= 1'b0;
						state <= txStartBit;
					end
				end
				txStartBit: begin
					if (bitDone) begin
						bitTimer <= '0;
						tx <= txByte[0];
						state <= txDataBits;
					end else begin
						bitTimer <= bitTimer + 1'b1;
					end
				end
				txDataBits: begin
					if (bitDone) begin
						bitTimer <= '0;
						if (bitIndex == lastDataBit) begin
							// stop bit follows the MSB.
							tx <= 1'b1;
							state <= txStopBit;
						end else begin
							bitIndex <= nextIndex;
							tx <= txByte[nextIndex];
						end
					end else begin
						bitTimer <= bitTimer + 1'b1;
					end
				end
				txStopBit: begin
					// tx is already high and the engine idles after one full bit.
					if (bitDone) begin
						bitTimer <= '0;
						state <= txIdle;
					end else begin
						bitTimer <= bitTimer + 1'b1;
					end
				end
				default: begin
					tx <= 1'b1;
					state <= txIdle;
				end
			endcase
		end
	end

	// line must rest high between frames.
	idleLineHigh: assert property (@(posedge clk) disable iff (rst)
		(state == txIdle) |-> tx)
		else $error("uartTx: tx low while idle");

	// busy only drops once a frame has run out through its stop bit.
	busyEndsAtStop: assert property (@(posedge clk) disable iff (rst)
		($fell(busy) && !$past(blockTransmission)) |-> $past(state == txStopBit))
		else $error("uartTx: busy dropped outside the stop bit");

endmodule
